/* project.f */
source/rvPkg.sv
source/regFile.sv
source/csrFile.sv
source/wbRegTop.sv
testbench/clockGen.sv
testbench/wbRegTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert -j 0 \
    --top-module wbRegTb \
    -Mdir "$BUILD_DIR/obj" \
    -f project.f

"./$BUILD_DIR/obj/VwbRegTb" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF '*** PASSED ***' "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* source/csrFile.sv */
`timescale 1ns/1ps
`default_nettype none

module csrFile #(
    parameter rvPkg::wordT HartId = '0
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire rvPkg::csrOpT   csrOp,
    input  wire rvPkg::csrAddrT csrAddr,
    input  wire rvPkg::wordT    csrOperand,
    output rvPkg::wordT         csrRdata,
    output logic                csrIllegal
);

    rvPkg::wordT mstatus;
    rvPkg::wordT mtvec;
    rvPkg::wordT mscratch;
    rvPkg::wordT mepc;
    rvPkg::wordT mcause;
    rvPkg::wordT mcycle;

    rvPkg::wordT oldVal;
    rvPkg::wordT newVal;

    logic hit;
    logic writable;
    logic doWrite;
    logic cycleWr;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode and read
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        hit      = 1'b1;
        writable = 1'b1;
        case (csrAddr)
            rvPkg::CsrMstatus:  oldVal = mstatus;
            rvPkg::CsrMtvec:    oldVal = mtvec;
            rvPkg::CsrMscratch: oldVal = mscratch;
            rvPkg::CsrMepc:     oldVal = mepc;
            rvPkg::CsrMcause:   oldVal = mcause;
            rvPkg::CsrMcycle:   oldVal = mcycle;
            rvPkg::CsrMhartid: begin
                // Read only
                oldVal   = HartId;
                writable = 1'b0;
            end
            default: begin
                oldVal   = '0;
                hit      = 1'b0;
                writable = 1'b0;
            end
        endcase
    end

    // Old value goes back to rd
    assign csrRdata   = oldVal;
    assign csrIllegal = !rst && (csrOp != rvPkg::CsrNone) && !hit;

    ////////////////////////////////////////////////////////////////////////////
    // Read-modify-write
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (csrOp)
            rvPkg::CsrWrite: newVal = csrOperand;
            rvPkg::CsrSet:   newVal = oldVal | csrOperand;
            rvPkg::CsrClear: newVal = oldVal & ~csrOperand;
            default:         newVal = oldVal;
        endcase
    end

    assign doWrite = (csrOp != rvPkg::CsrNone) && writable;
    assign cycleWr = doWrite && (csrAddr == rvPkg::CsrMcycle);

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (doWrite) begin
            case (csrAddr)
                rvPkg::CsrMstatus:  mstatus  <= newVal;
                rvPkg::CsrMtvec:    mtvec    <= newVal;
                rvPkg::CsrMscratch: mscratch <= newVal;
                rvPkg::CsrMepc:     mepc     <= newVal;
                rvPkg::CsrMcause:   mcause   <= newVal;
                default: begin
                end
            endcase
        end
    end

    // Free-running cycle counter where a CSR write wins over the increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
        end else if (cycleWr) begin
            mcycle <= newVal;
        end else begin
            mcycle <= mcycle + rvPkg::wordT'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // An illegal access leaves every writable CSR as it was
    aIllegalNoEffect: assert property (
        @(posedge clk) disable iff (rst)
        csrIllegal |=> ($stable(mstatus) && $stable(mtvec) && $stable(mscratch)
                        && $stable(mepc) && $stable(mcause))
    );

    // Counter advances by exactly one when not reloaded
    aCycleStep: assert property (
        @(posedge clk) disable iff (rst)
        !cycleWr |=> (mcycle == $past(mcycle) + rvPkg::wordT'(1))
    );

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile #(
    parameter int NumRegs = 32
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 regWe,
    input  wire rvPkg::regAddrT rd,
    input  wire rvPkg::regAddrT rs1,
    input  wire rvPkg::regAddrT rs2,
    input  wire rvPkg::wbSelT   wbSel,
    input  wire rvPkg::wordT    pc,
    input  wire rvPkg::wordT    aluOut,
    input  wire rvPkg::wordT    dmemOut,
    input  wire rvPkg::wordT    csrRdata,
    output rvPkg::wordT         rdata1,
    output rvPkg::wordT         rdata2
);

    // Index bits actually needed to address the array
    localparam int IdxW = (NumRegs > 1) ? $clog2(NumRegs) : 1;

    rvPkg::wordT regs [NumRegs];

    rvPkg::wordT pcLink;
    rvPkg::wordT wbData;

    logic wrEn;
    logic rdInRange;
    logic rs1InRange;
    logic rs2InRange;

    ////////////////////////////////////////////////////////////////////////////
    // Writeback source select
    ////////////////////////////////////////////////////////////////////////////

    // Link address for jal / jalr
    assign pcLink = pc + rvPkg::wordT'(4);

    always_comb begin
        case (wbSel)
            rvPkg::WbMem:    wbData = dmemOut;
            rvPkg::WbAlu:    wbData = aluOut;
            rvPkg::WbPcLink: wbData = pcLink;
            rvPkg::WbCsr:    wbData = csrRdata;
            default:         wbData = aluOut;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register array
    ////////////////////////////////////////////////////////////////////////////

    // Upper indexes do not exist on an RV32E build
    assign rdInRange  = (int'(rd) < NumRegs);
    assign rs1InRange = (int'(rs1) < NumRegs);
    assign rs2InRange = (int'(rs2) < NumRegs);

    // x0 is never a destination
    assign wrEn = regWe && (rd != '0) && rdInRange;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[rd[IdxW-1:0]] <= wbData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports with same-cycle forwarding
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!rs1InRange || (rs1 == '0)) begin
            rdata1 = '0;
        end else if (wrEn && (rs1 == rd)) begin
            rdata1 = wbData;
        end else begin
            rdata1 = regs[rs1[IdxW-1:0]];
        end
    end

    always_comb begin
        if (!rs2InRange || (rs2 == '0)) begin
            rdata2 = '0;
        end else if (wrEn && (rs2 == rd)) begin
            rdata2 = wbData;
        end else begin
            rdata2 = regs[rs2[IdxW-1:0]];
        end
    end

    // Decode never retires a write past the last implemented register
    aWriteInRange: assert property (
        @(posedge clk) disable iff (rst)
        regWe |-> rdInRange
    );

endmodule

`default_nettype wire

/* source/rvPkg.sv */
`default_nettype none

package rvPkg;

    // Data path width
    localparam int Xlen = 32;

    typedef logic [Xlen-1:0] wordT;
    typedef logic [4:0]      regAddrT;
    typedef logic [11:0]     csrAddrT;

    // Writeback source select
    typedef enum logic [1:0] {
        WbMem    = 2'd0,
        WbAlu    = 2'd1,
        WbPcLink = 2'd2,
        WbCsr    = 2'd3
    } wbSelT;

    // CSR access type as in csrrw / csrrs / csrrc
    typedef enum logic [1:0] {
        CsrNone  = 2'd0,
        CsrWrite = 2'd1,
        CsrSet   = 2'd2,
        CsrClear = 2'd3
    } csrOpT;

    ////////////////////////////////////////////////////////////////////////////
    // Machine mode CSR addresses
    ////////////////////////////////////////////////////////////////////////////

    localparam csrAddrT CsrMstatus  = 12'h300;
    localparam csrAddrT CsrMtvec    = 12'h305;
    localparam csrAddrT CsrMscratch = 12'h340;
    localparam csrAddrT CsrMepc     = 12'h341;
    localparam csrAddrT CsrMcause   = 12'h342;

    // Counter and ID
    localparam csrAddrT CsrMcycle   = 12'hB00;
    localparam csrAddrT CsrMhartid  = 12'hF14;

endpackage

`default_nettype wire

/* source/wbRegTop.sv */
`timescale 1ns/1ps
`default_nettype none

module wbRegTop #(
    parameter int          NumRegs = 32,
    parameter rvPkg::wordT HartId  = '0
) (
    input  wire                 clk,
    input  wire                 rst,

    // Retiring instruction
    input  wire                 regWe,
    input  wire rvPkg::regAddrT rd,
    input  wire rvPkg::regAddrT rs1,
    input  wire rvPkg::regAddrT rs2,
    input  wire rvPkg::wbSelT   wbSel,
    input  wire rvPkg::wordT    pc,
    input  wire rvPkg::wordT    aluOut,
    input  wire rvPkg::wordT    dmemOut,

    // CSR access
    input  wire rvPkg::csrOpT   csrOp,
    input  wire rvPkg::csrAddrT csrAddr,
    input  wire rvPkg::wordT    csrOperand,

    output rvPkg::wordT         rdata1,
    output rvPkg::wordT         rdata2,
    output logic                csrIllegal
);

    // Old CSR value for the WbCsr writeback source
    rvPkg::wordT csrRdata;

    ////////////////////////////////////////////////////////////////////////////
    // Integer register file
    ////////////////////////////////////////////////////////////////////////////

    regFile #(
        .NumRegs (NumRegs)
    ) uRegFile (
        .clk      (clk),
        .rst      (rst),
        .regWe    (regWe),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .wbSel    (wbSel),
        .pc       (pc),
        .aluOut   (aluOut),
        .dmemOut  (dmemOut),
        .csrRdata (csrRdata),
        .rdata1   (rdata1),
        .rdata2   (rdata2)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Machine CSRs
    ////////////////////////////////////////////////////////////////////////////

    csrFile #(
        .HartId (HartId)
    ) uCsrFile (
        .clk        (clk),
        .rst        (rst),
        .csrOp      (csrOp),
        .csrAddr    (csrAddr),
        .csrOperand (csrOperand),
        .csrRdata   (csrRdata),
        .csrIllegal (csrIllegal)
    );

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // Synchronous reset released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/wbRegTb.sv */
`timescale 1ns/1ps
`default_nettype none

module wbRegTb;

    localparam int          NumRegs        = 32;
    localparam rvPkg::wordT HartId         = 32'h0000_0003;
    localparam int          ClkPeriodNs    = 40;
    localparam int          ResetCycles    = 10;
    localparam int          DirectedCycles = 100;
    localparam int          RandomCycles   = 2000;
    localparam int          SettleNs       = 5;
    // One and a half times the planned run
    localparam int          TimeoutNs      =
        (ResetCycles + DirectedCycles + RandomCycles) * ClkPeriodNs * 3 / 2;

    logic clk;
    logic rst;

    // DUT inputs stay idle until the first retirement
    logic           regWe      = 1'b0;
    rvPkg::regAddrT rd         = '0;
    rvPkg::regAddrT rs1        = '0;
    rvPkg::regAddrT rs2        = '0;
    rvPkg::wbSelT   wbSel      = rvPkg::WbAlu;
    rvPkg::wordT    pc         = '0;
    rvPkg::wordT    aluOut     = '0;
    rvPkg::wordT    dmemOut    = '0;
    rvPkg::csrOpT   csrOp      = rvPkg::CsrNone;
    rvPkg::csrAddrT csrAddr    = rvPkg::CsrMstatus;
    rvPkg::wordT    csrOperand = '0;

    rvPkg::wordT rdata1;
    rvPkg::wordT rdata2;
    logic        csrIllegal;

    // Reference model state
    rvPkg::wordT refRegs [32];
    rvPkg::wordT refMstatus  = '0;
    rvPkg::wordT refMtvec    = '0;
    rvPkg::wordT refMscratch = '0;
    rvPkg::wordT refMepc     = '0;
    rvPkg::wordT refMcause   = '0;
    rvPkg::wordT refCycle    = '0;

    // Writable CSRs first, then mcycle and mhartid
    rvPkg::csrAddrT implCsrs [7] = '{rvPkg::CsrMstatus, rvPkg::CsrMtvec, rvPkg::CsrMscratch,
                                     rvPkg::CsrMepc, rvPkg::CsrMcause, rvPkg::CsrMcycle,
                                     rvPkg::CsrMhartid};
    rvPkg::csrAddrT badCsrs [5]  = '{12'h301, 12'h7C0, 12'hB80, 12'hFFF, 12'h000};

    integer seed     = 32'ha7a2_9b42;
    int     cycleNum = 0;
    int     errCount = 0;

    clockGen #(.PeriodNs(ClkPeriodNs), .ResetCycles(ResetCycles)) uClk (.clk(clk), .rst(rst));

    wbRegTop #(.NumRegs(NumRegs), .HartId(HartId)) uut (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic rvPkg::wordT randWord();
        return rvPkg::wordT'($random(seed));
    endfunction

    function automatic logic csrKnown(input rvPkg::csrAddrT addr);
        return addr inside {rvPkg::CsrMstatus, rvPkg::CsrMtvec, rvPkg::CsrMscratch,
                            rvPkg::CsrMepc, rvPkg::CsrMcause, rvPkg::CsrMcycle,
                            rvPkg::CsrMhartid};
    endfunction

    function automatic rvPkg::wordT csrValue(input rvPkg::csrAddrT addr);
        case (addr)
            rvPkg::CsrMstatus:  return refMstatus;
            rvPkg::CsrMtvec:    return refMtvec;
            rvPkg::CsrMscratch: return refMscratch;
            rvPkg::CsrMepc:     return refMepc;
            rvPkg::CsrMcause:   return refMcause;
            rvPkg::CsrMcycle:   return refCycle;
            rvPkg::CsrMhartid:  return HartId;
            default:            return '0;
        endcase
    endfunction

    function automatic rvPkg::wordT wbValue();
        case (wbSel)
            rvPkg::WbMem:    return dmemOut;
            rvPkg::WbAlu:    return aluOut;
            rvPkg::WbPcLink: return pc + 32'd4;
            default:         return csrValue(csrAddr);
        endcase
    endfunction

    function automatic logic regWritten();
        return regWe && (rd != '0) && (int'(rd) < NumRegs);
    endfunction

    function automatic rvPkg::wordT readPortValue(input rvPkg::regAddrT idx);
        if ((idx == '0) || (int'(idx) >= NumRegs)) return '0;
        // Same-cycle write is forwarded
        if (regWritten() && (idx == rd)) return wbValue();
        return refRegs[idx];
    endfunction

    // State update at a rising edge
    task automatic commitEdge();
        rvPkg::wordT oldCsr;
        rvPkg::wordT newCsr;
        oldCsr = csrValue(csrAddr);
        case (csrOp)
            rvPkg::CsrWrite: newCsr = csrOperand;
            rvPkg::CsrSet:   newCsr = oldCsr | csrOperand;
            default:         newCsr = oldCsr & ~csrOperand;
        endcase
        if (regWritten()) refRegs[rd] = wbValue();
        refCycle = refCycle + 32'd1;
        if (csrOp != rvPkg::CsrNone) begin
            case (csrAddr)
                rvPkg::CsrMstatus:  refMstatus  = newCsr;
                rvPkg::CsrMtvec:    refMtvec    = newCsr;
                rvPkg::CsrMscratch: refMscratch = newCsr;
                rvPkg::CsrMepc:     refMepc     = newCsr;
                rvPkg::CsrMcause:   refMcause   = newCsr;
                rvPkg::CsrMcycle:   refCycle    = newCsr;
                default: begin
                end
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and one retirement per cycle
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkWord(input string name, input rvPkg::wordT actual,
                             input rvPkg::wordT expected);
        if (actual !== expected) begin
            errCount++;
            $display("Error: %s = 0x%08h, expected 0x%08h in cycle %0d",
                     name, actual, expected, cycleNum);
            $display("*** FAILED ***");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errCount++;
            $display("Error: %s = 0x%0h, expected 0x%0h in cycle %0d",
                     name, actual, expected, cycleNum);
            $display("*** FAILED ***");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic retire(input logic we, input rvPkg::regAddrT dst,
                          input rvPkg::regAddrT src1, input rvPkg::regAddrT src2,
                          input rvPkg::wbSelT sel, input rvPkg::csrOpT op,
                          input rvPkg::csrAddrT addr);
        regWe      = we;
        rd         = dst;
        rs1        = src1;
        rs2        = src2;
        wbSel      = sel;
        pc         = randWord() & ~32'h3;
        aluOut     = randWord();
        dmemOut    = randWord();
        csrOperand = randWord();
        csrOp      = op;
        csrAddr    = addr;
        #(SettleNs);
        checkWord("rdata1", rdata1, readPortValue(rs1));
        checkWord("rdata2", rdata2, readPortValue(rs2));
        checkFlag("csrIllegal", csrIllegal, (csrOp != rvPkg::CsrNone) && !csrKnown(csrAddr));
        @(posedge clk);
        commitEdge();
        cycleNum++;
        @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rvPkg::regAddrT dst;
        rvPkg::wordT    r;
        rvPkg::wordT    s;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end

        // csrIllegal stays low while reset is held
        @(negedge clk);
        csrOp   = rvPkg::CsrWrite;
        csrAddr = badCsrs[1];
        #(SettleNs);
        checkFlag("csrIllegal", csrIllegal, 1'b0);
        @(negedge clk);
        csrOp   = rvPkg::CsrNone;
        csrAddr = rvPkg::CsrMstatus;
        @(negedge rst);

        // Every writeback source, then a write to x0
        for (int i = 0; i < 4; i++) begin
            retire(1'b1, 5'(5 + i), 5'd0, 5'd0, rvPkg::wbSelT'(2'(i)), rvPkg::CsrNone,
                   rvPkg::CsrMhartid);
            retire(1'b0, 5'd0, 5'(5 + i), 5'd0, rvPkg::WbAlu, rvPkg::CsrNone, rvPkg::CsrMhartid);
        end
        retire(1'b1, 5'd0, 5'd0, 5'd0, rvPkg::WbAlu, rvPkg::CsrNone, rvPkg::CsrMstatus);
        retire(1'b0, 5'd0, 5'd0, 5'd0, rvPkg::WbAlu, rvPkg::CsrNone, rvPkg::CsrMstatus);

        // Forwarding on one or both read ports
        for (int i = 0; i < 8; i++) begin
            dst = 5'(1 + (randWord() % 31));
            retire(1'b1, dst, dst, (i % 2 == 1) ? dst : rvPkg::regAddrT'(randWord()),
                   rvPkg::wbSelT'(2'(i)), rvPkg::CsrNone, rvPkg::CsrMscratch);
            retire(1'b0, 5'd0, dst, dst, rvPkg::WbAlu, rvPkg::CsrNone, rvPkg::CsrMscratch);
        end

        // Write, set and clear on each writable CSR
        for (int i = 0; i < 5; i++) begin
            for (int k = 1; k < 4; k++) begin
                retire(1'b1, 5'(9 + k), 5'(9 + k), 5'(8 + k), rvPkg::WbCsr,
                       rvPkg::csrOpT'(2'(k)), implCsrs[i]);
            end
            retire(1'b1, 5'd13, 5'd13, 5'd12, rvPkg::WbCsr, rvPkg::CsrNone, implCsrs[i]);
        end

        // mcycle reload, then mhartid ignoring writes
        for (int k = 0; k < 4; k++) begin
            retire(1'b1, 5'd14, 5'd14, 5'd0, rvPkg::WbCsr, rvPkg::csrOpT'(2'(k)),
                   rvPkg::CsrMcycle);
            retire(1'b1, 5'd14, 5'd14, 5'd0, rvPkg::WbCsr, rvPkg::CsrNone, rvPkg::CsrMcycle);
        end
        for (int k = 0; k < 4; k++) begin
            retire(1'b1, 5'd15, 5'd15, 5'd0, rvPkg::WbCsr, rvPkg::csrOpT'(2'(k)),
                   rvPkg::CsrMhartid);
        end

        // Unimplemented addresses, then every CSR read back
        for (int i = 0; i < 5; i++) begin
            retire(1'b1, 5'd16, 5'd16, 5'd0, rvPkg::WbCsr, rvPkg::csrOpT'(2'(1 + i % 3)),
                   badCsrs[i]);
        end
        for (int i = 0; i < 7; i++) begin
            retire(1'b1, 5'd17, 5'd17, 5'd0, rvPkg::WbCsr, rvPkg::CsrNone, implCsrs[i]);
        end

        // Random mix mostly on implemented CSRs
        for (int n = 0; n < RandomCycles; n++) begin
            r = randWord();
            s = randWord();
            retire(r[1:0] != 2'b00, r[6:2],
                   (s[1:0] == 2'b00) ? r[6:2] : s[6:2],
                   (s[8:7] == 2'b00) ? r[6:2] : s[13:9],
                   rvPkg::wbSelT'(r[8:7]),
                   r[9] ? rvPkg::csrOpT'(r[11:10]) : rvPkg::CsrNone,
                   (r[14:12] != 3'b000) ? implCsrs[int'(s[31:16]) % 7] : s[27:16]);
        end

        // Final sweep of the register array
        for (int i = 0; i < 16; i++) begin
            retire(1'b0, 5'd0, 5'(2 * i), 5'(2 * i + 1), rvPkg::WbAlu, rvPkg::CsrNone,
                   rvPkg::CsrMstatus);
        end

        if (errCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TimeoutNs);
        $display("Timeout: the tests did not finish within %0d ns", TimeoutNs);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
